// ==== files.f ====
+incdir+include
verilog/masku_pkg.sv
verilog/masku_sequencer.sv
verilog/masku_lane_slice.sv
verilog/masku_collector.sv
verilog/masku_top.sv
testbench/tb_clkgen.sv
testbench/masku_tb.sv

// ==== include/masku_config.svh ====
// Sizing macros for the mask unit; include wherever lane count or widths are needed
`ifndef MASKU_CONFIG_SVH
`define MASKU_CONFIG_SVH

//////////////////////////////
// Datapath geometry
//////////////////////////////

// Lanes working side by side on one operand beat
`define MASKU_NR_LANES 4

// Bits per lane word
`define MASKU_ELEN 64

//////////////////////////////
// Counter and id widths
//////////////////////////////

// vl and remaining-bit counters
`define MASKU_VL_W 12

// Instruction id carried through to done
`define MASKU_ID_W 3

// Scalar result returned by vcpop
`define MASKU_XLEN 64

`endif

// ==== testbench/masku_tb.sv ====
// Self-checking testbench of masku_top; runs merge and vcpop instructions under back-pressure
`default_nettype none
`timescale 1ns/1ps

`include "masku_config.svh"

module masku_tb;

  localparam int NR_LANES  = `MASKU_NR_LANES;
  localparam int ELEN      = `MASKU_ELEN;
  localparam int BEAT_BITS = NR_LANES * ELEN;
  localparam int NR_RANDOM = 8;
  // Worst case beats over all tests, 20 cycles each plus reset
  localparam int TOTAL_BEATS     = 2 + 2 + 4 + NR_RANDOM * 4;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 8;

  typedef masku_pkg::lane_word_t [NR_LANES-1:0] beat_word_t;
  typedef masku_pkg::lane_strb_t [NR_LANES-1:0] beat_strb_t;

  logic                                    clk_i;
  logic                                    rst_ni;
  masku_pkg::masku_req_t                   req_i;
  logic                                    req_valid_i;
  logic                                    req_ready_o;
  masku_pkg::lane_operand_t [NR_LANES-1:0] opnd_i;
  logic                                    opnd_valid_i;
  logic                                    opnd_ready_o;
  beat_word_t                              res_wdata_o;
  beat_strb_t                              res_be_o;
  logic                                    res_valid_o;
  logic                                    res_ready_i;
  masku_pkg::scalar_t                      scalar_o;
  logic                                    scalar_valid_o;
  logic                                    scalar_ready_i;
  logic                                    done_o;
  masku_pkg::insn_id_t                     done_id_o;

  // Expected items in transfer order
  beat_word_t          exp_wdata_q[$];
  beat_strb_t          exp_be_q[$];
  bit                  exp_last_q[$];
  masku_pkg::scalar_t  exp_scalar_q[$];
  masku_pkg::insn_id_t exp_id_q[$];

  integer seed       = 32'h40ad_a15c;
  integer ready_seed = 32'h40ad_a15c;
  int     check_cnt  = 0;
  int     err_cnt    = 0;
  int     err_mark   = 0;
  bit     bp_on      = 1'b0;
  bit     done_expect = 1'b0;

  tb_clkgen i_clkgen (.clk_o(clk_i), .rst_no(rst_ni));

  masku_top uut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .req_i (req_i), .req_valid_i (req_valid_i), .req_ready_o (req_ready_o),
    .opnd_i (opnd_i), .opnd_valid_i (opnd_valid_i), .opnd_ready_o (opnd_ready_o),
    .res_wdata_o (res_wdata_o), .res_be_o (res_be_o),
    .res_valid_o (res_valid_o), .res_ready_i (res_ready_i),
    .scalar_o (scalar_o), .scalar_valid_o (scalar_valid_o), .scalar_ready_i (scalar_ready_i),
    .done_o (done_o), .done_id_o (done_id_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_val(input string name, input logic [255:0] got, input logic [255:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic require(input bit cond, input string what);
    check_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  function automatic masku_pkg::lane_word_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // Expected merge beat and popcount from the enable rule on global bit indices
  function automatic void ref_beat(input masku_pkg::masku_req_t req, input int beat,
                                  input masku_pkg::lane_operand_t [NR_LANES-1:0] opnd,
                                  output beat_word_t wdata, output beat_strb_t be,
                                  output int pop);
    int idx;
    bit en;
    pop = 0;
    for (int l = 0; l < NR_LANES; l++) begin
      for (int k = 0; k < ELEN; k++) begin
        idx = beat * BEAT_BITS + l * ELEN + k;
        en  = (idx < req.vl) && (req.vm || opnd[l].m[k]);
        wdata[l][k] = en ? opnd[l].a[k] : opnd[l].b[k];
        if (en && opnd[l].b[k]) pop++;
      end
      // Byte written when its first bit lies below vl
      for (int j = 0; j < ELEN / 8; j++) begin
        be[l][j] = (beat * BEAT_BITS + l * ELEN + 8 * j) < req.vl;
      end
    end
  endfunction

  // One instruction: request, then all operand beats; expected items queued on the way
  task automatic run_insn(input masku_pkg::masku_op_e op, input bit vm, input int vl,
                          input int id);
    masku_pkg::masku_req_t                   req;
    masku_pkg::lane_operand_t [NR_LANES-1:0] opnd;
    beat_word_t                              wdata;
    beat_strb_t                              be;
    int                                      pop;
    int                                      nbeats;
    masku_pkg::scalar_t                      total;
    req = '{op: op, vm: vm, vl: masku_pkg::vlen_t'(vl), id: masku_pkg::insn_id_t'(id)};
    nbeats = (vl + BEAT_BITS - 1) / BEAT_BITS;
    total = '0;
    exp_id_q.push_back(req.id);
    req_i = req;
    req_valid_i = 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #10;
    req_valid_i = 1'b0;
    for (int n = 0; n < nbeats; n++) begin
      for (int l = 0; l < NR_LANES; l++) begin
        opnd[l].a = rand_word();
        opnd[l].b = rand_word();
        opnd[l].m = rand_word();
      end
      ref_beat(req, n, opnd, wdata, be, pop);
      if (op == masku_pkg::MASKU_OP_MERGE) begin
        exp_wdata_q.push_back(wdata);
        exp_be_q.push_back(be);
        exp_last_q.push_back(n == nbeats - 1);
      end else begin
        total = total + masku_pkg::scalar_t'(pop);
        if (n == nbeats - 1) exp_scalar_q.push_back(total);
      end
      opnd_i = opnd;
      opnd_valid_i = 1'b1;
      do @(negedge clk_i); while (!opnd_ready_o);
      @(posedge clk_i);
      #10;
    end
    opnd_valid_i = 1'b0;
  endtask

  // Waits until every expected item and done pulse has been seen
  task automatic finish_test(input string name);
    while (exp_wdata_q.size() != 0 || exp_scalar_q.size() != 0 || exp_id_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #10;
    $display("test %s finished with %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  //////////////////////////////
  // Comparing process
  //////////////////////////////

  // Sampled at the falling edge, where inputs and outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Done due one cycle after the last item left
      if (done_expect) begin
        check_val("done_o", done_o, 1'b1);
        require(exp_id_q.size() != 0, "done pulse with no instruction outstanding");
        if (exp_id_q.size() != 0) check_val("done_id_o", done_id_o, exp_id_q.pop_front());
      end else begin
        require(!done_o, "done_o pulsed without a finished instruction");
      end
      done_expect = 1'b0;
      if (res_valid_o && res_ready_i) begin
        require(exp_wdata_q.size() != 0, "result beat arrived with none expected");
        if (exp_wdata_q.size() != 0) begin
          check_val("res_wdata_o", res_wdata_o, exp_wdata_q.pop_front());
          check_val("res_be_o", res_be_o, exp_be_q.pop_front());
          done_expect = exp_last_q.pop_front();
        end
      end
      if (scalar_valid_o && scalar_ready_i) begin
        require(exp_scalar_q.size() != 0, "scalar arrived with none expected");
        if (exp_scalar_q.size() != 0) check_val("scalar_o", scalar_o, exp_scalar_q.pop_front());
        done_expect = 1'b1;
      end
    end
  end

  // Ready inputs, random while back-pressure is on
  always @(posedge clk_i) begin
    #10;
    res_ready_i    = bp_on ? $random(ready_seed) & 1 : 1'b1;
    scalar_ready_i = bp_on ? $random(ready_seed) & 1 : 1'b1;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("timeout after %0d cycles, instructions did not complete", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    req_i          = '0;
    req_valid_i    = 1'b0;
    opnd_i         = '0;
    opnd_valid_i   = 1'b0;
    res_ready_i    = 1'b1;
    scalar_ready_i = 1'b1;
    wait (rst_ni);
    @(posedge clk_i);
    #10;

    // Idle state straight after reset
    @(negedge clk_i);
    check_val("opnd_ready_o", opnd_ready_o, 1'b0);
    check_val("res_valid_o", res_valid_o, 1'b0);
    check_val("scalar_valid_o", scalar_valid_o, 1'b0);
    check_val("done_o", done_o, 1'b0);
    check_val("req_ready_o", req_ready_o, 1'b1);
    finish_test("reset_state");

    // Two full beats, no mask
    run_insn(masku_pkg::MASKU_OP_MERGE, 1'b1, 2 * BEAT_BITS, 1);
    finish_test("unmasked_merge");

    // Second beat only partly below vl
    run_insn(masku_pkg::MASKU_OP_MERGE, 1'b0,
             BEAT_BITS + 1 + $unsigned($random(seed)) % (BEAT_BITS - 2), 2);
    finish_test("masked_partial_merge");

    run_insn(masku_pkg::MASKU_OP_VCPOP, 1'b0, 520 + $unsigned($random(seed)) % 400, 3);
    finish_test("masked_vcpop");

    // Back to back instructions, mixed ops, random ready
    bp_on = 1'b1;
    for (int i = 0; i < NR_RANDOM; i++) begin
      run_insn(masku_pkg::masku_op_e'($random(seed) & 1), $random(seed) & 1,
               1 + $unsigned($random(seed)) % (4 * BEAT_BITS), (4 + i) % 8);
    end
    finish_test("backpressure_mix");
    bp_on = 1'b0;

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// Testbench clock and reset source; drives clk_o with a 100 ns period and holds rst_no low
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned HALF_PERIOD = 50,
  parameter int unsigned RST_CYCLES  = 8
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release reset just after an edge, clear of the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/masku_collector.sv ====
// Mask unit back end: drains the lane stage into result beats or the vcpop scalar, flags done
`default_nettype none
`timescale 1ns/1ps

`include "masku_config.svh"

module masku_collector (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_ni,
  // Lane stage
  input  wire masku_pkg::lane_result_t [`MASKU_NR_LANES-1:0] lane_res_i,
  input  wire masku_pkg::beat_info_t                       beat_info_i,
  input  wire logic                                        stage_valid_i,
  output logic                                             stage_ready_o,
  // Result channel
  output masku_pkg::lane_word_t [`MASKU_NR_LANES-1:0]      res_wdata_o,
  output masku_pkg::lane_strb_t [`MASKU_NR_LANES-1:0]      res_be_o,
  output logic                                             res_valid_o,
  input  wire logic                                        res_ready_i,
  // Scalar channel
  output masku_pkg::scalar_t                               scalar_o,
  output logic                                             scalar_valid_o,
  input  wire logic                                        scalar_ready_i,
  // Completion
  output logic                                             done_o,
  output masku_pkg::insn_id_t                              done_id_o
);

  localparam int unsigned NR_LANES = `MASKU_NR_LANES;

  //////////////////////////////
  // Stage drain
  //////////////////////////////

  logic res_valid_q;
  logic res_last_q;
  logic scalar_valid_q;
  logic res_fire;
  logic scalar_fire;
  logic take;
  logic take_merge;
  logic take_pop;

  masku_pkg::lane_word_t [NR_LANES-1:0] res_wdata_q;
  masku_pkg::lane_strb_t [NR_LANES-1:0] res_be_q;
  masku_pkg::scalar_t                   acc_q;
  masku_pkg::scalar_t                   scalar_q;
  masku_pkg::scalar_t                   beat_sum;
  masku_pkg::insn_id_t                  pend_id_q;
  masku_pkg::insn_id_t                  done_id_q;
  logic                                 done_q;

  assign res_fire    = res_valid_q && res_ready_i;
  assign scalar_fire = scalar_valid_q && scalar_ready_i;

  // Blocked by a stuck result beat or a stuck scalar
  assign stage_ready_o = !(res_valid_q && !res_ready_i) && !(scalar_valid_q && !scalar_ready_i);

  assign take       = stage_valid_i && stage_ready_o;
  assign take_merge = take && (beat_info_i.op == masku_pkg::MASKU_OP_MERGE);
  assign take_pop   = take && (beat_info_i.op == masku_pkg::MASKU_OP_VCPOP);

  // Popcounts of all lanes in this beat
  always_comb begin
    beat_sum = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      beat_sum = beat_sum + masku_pkg::scalar_t'(lane_res_i[l].popcnt);
    end
  end

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q    <= 1'b0;
      res_last_q     <= 1'b0;
      scalar_valid_q <= 1'b0;
      acc_q          <= '0;
      done_q         <= 1'b0;
    end else begin
      // Result register refills or empties
      if (take_merge) begin
        res_valid_q <= 1'b1;
        res_last_q  <= beat_info_i.last;
      end else if (res_fire) begin
        res_valid_q <= 1'b0;
      end
      // Scalar rises with the last vcpop beat
      if (take_pop && beat_info_i.last) begin
        scalar_valid_q <= 1'b1;
      end else if (scalar_fire) begin
        scalar_valid_q <= 1'b0;
      end
      // Accumulator clears on the last beat
      if (take_pop) begin
        acc_q <= beat_info_i.last ? '0 : acc_q + beat_sum;
      end
      // One pulse after the last item leaves
      done_q <= (res_fire && res_last_q) || scalar_fire;
    end
  end

  // Payload: result beat, scalar and ids
  always_ff @(posedge clk_i) begin
    if (take_merge) begin
      for (int l = 0; l < NR_LANES; l++) begin
        res_wdata_q[l] <= lane_res_i[l].wdata;
        res_be_q[l]    <= lane_res_i[l].be;
      end
    end
    if (take_pop && beat_info_i.last) begin
      scalar_q <= acc_q + beat_sum;
    end
    // At most one last item waits at a time
    if (take && beat_info_i.last) begin
      pend_id_q <= beat_info_i.id;
    end
    if ((res_fire && res_last_q) || scalar_fire) begin
      done_id_q <= pend_id_q;
    end
  end

  assign res_wdata_o    = res_wdata_q;
  assign res_be_o       = res_be_q;
  assign res_valid_o    = res_valid_q;
  assign scalar_o       = scalar_q;
  assign scalar_valid_o = scalar_valid_q;
  assign done_o         = done_q;
  assign done_id_o      = done_id_q;

endmodule

`default_nettype wire

// ==== verilog/masku_lane_slice.sv ====
// One lane of the mask unit: bit enable, merge and popcount, registered per operand beat
`default_nettype none
`timescale 1ns/1ps

`include "masku_config.svh"

module masku_lane_slice #(
  parameter int unsigned LANE_IDX = 0
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire masku_pkg::lane_ctrl_t    lane_ctrl_i,
  input  wire masku_pkg::lane_operand_t lane_opnd_i,
  input  wire logic                     beat_load_i,
  output masku_pkg::lane_result_t       lane_res_o
);

  localparam int unsigned ELEN  = `MASKU_ELEN;
  localparam int unsigned NR_BYTES = ELEN / 8;
  // First bit of this lane inside the beat
  localparam int unsigned BASE = LANE_IDX * ELEN;

  //////////////////////////////
  // Bit enable
  //////////////////////////////

  masku_pkg::lane_word_t  vl_en;
  masku_pkg::lane_word_t  bit_en;
  masku_pkg::lane_strb_t  byte_en;
  masku_pkg::lane_word_t  count_src;
  masku_pkg::popcnt_t     count;
  masku_pkg::lane_result_t lane_res_d;
  masku_pkg::lane_result_t lane_res_q;

  always_comb begin
    // Bits below the remaining count
    for (int k = 0; k < ELEN; k++) begin
      vl_en[k] = (BASE + k) < lane_ctrl_i.remaining;
    end
    // Masked instructions also need the m bit
    bit_en = lane_ctrl_i.vm ? vl_en : (vl_en & lane_opnd_i.m);
    // A byte is written if any of its bits lies below vl
    for (int j = 0; j < NR_BYTES; j++) begin
      byte_en[j] = |vl_en[8*j +: 8];
    end
  end

  //////////////////////////////
  // Popcount
  //////////////////////////////

  assign count_src = lane_opnd_i.b & bit_en;

  always_comb begin
    count = '0;
    for (int k = 0; k < ELEN; k++) begin
      count = count + masku_pkg::popcnt_t'(count_src[k]);
    end
  end

  // Op picks which part of the result carries data
  always_comb begin
    lane_res_d = '0;
    if (lane_ctrl_i.op == masku_pkg::MASKU_OP_MERGE) begin
      // a where enabled, old destination elsewhere
      lane_res_d.wdata = (lane_opnd_i.a & bit_en) | (lane_opnd_i.b & ~bit_en);
      lane_res_d.be    = byte_en;
    end else begin
      lane_res_d.popcnt = count;
    end
  end

  // Output register, loads with the accepted beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_res_q <= '0;
    end else if (beat_load_i) begin
      lane_res_q <= lane_res_d;
    end
  end

  assign lane_res_o = lane_res_q;

endmodule

`default_nettype wire

// ==== verilog/masku_pkg.sv ====
// Shared types of the mask unit; refer to them as masku_pkg::name from RTL and testbench
`default_nettype none

`include "masku_config.svh"

package masku_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // One lane word and its byte enables
  typedef logic [`MASKU_ELEN-1:0]   lane_word_t;
  typedef logic [`MASKU_ELEN/8-1:0] lane_strb_t;

  // vl and remaining-bit counts
  typedef logic [`MASKU_VL_W-1:0] vlen_t;

  // Instruction id
  typedef logic [`MASKU_ID_W-1:0] insn_id_t;

  // Set bits of one lane word, 0 up to ELEN inclusive
  typedef logic [$clog2(`MASKU_ELEN):0] popcnt_t;

  // Scalar result
  typedef logic [`MASKU_XLEN-1:0] scalar_t;

  // Supported operations
  typedef enum logic {
    MASKU_OP_MERGE,
    MASKU_OP_VCPOP
  } masku_op_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // One instruction on the request channel
  typedef struct packed {
    masku_op_e op;
    logic      vm;
    vlen_t     vl;
    insn_id_t  id;
  } masku_req_t;

  // One lane's share of an operand beat
  // a is the mask-logical result, b the old destination, m the mask register
  typedef struct packed {
    lane_word_t a;
    lane_word_t b;
    lane_word_t m;
  } lane_operand_t;

  // Beat control broadcast to every lane
  typedef struct packed {
    masku_op_e op;
    logic      vm;
    vlen_t     remaining;
  } lane_ctrl_t;

  // Sideband that travels next to the lane stage
  typedef struct packed {
    masku_op_e op;
    insn_id_t  id;
    logic      last;
  } beat_info_t;

  // Registered output of one lane
  typedef struct packed {
    lane_word_t wdata;
    lane_strb_t be;
    popcnt_t    popcnt;
  } lane_result_t;

endpackage

`default_nettype wire

// ==== verilog/masku_sequencer.sv ====
// Mask unit front end: holds one instruction and feeds its operand beats to the lane stage
`default_nettype none
`timescale 1ns/1ps

`include "masku_config.svh"

module masku_sequencer (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  // Request channel
  input  wire masku_pkg::masku_req_t                      req_i,
  input  wire logic                                       req_valid_i,
  output logic                                            req_ready_o,
  // Operand channel
  input  wire masku_pkg::lane_operand_t [`MASKU_NR_LANES-1:0] opnd_i,
  input  wire logic                                       opnd_valid_i,
  output logic                                            opnd_ready_o,
  // Collector can drain the lane stage
  input  wire logic                                       stage_ready_i,
  // Lane stage inputs
  output masku_pkg::lane_ctrl_t                           lane_ctrl_o,
  output masku_pkg::lane_operand_t [`MASKU_NR_LANES-1:0]  lane_opnd_o,
  output logic                                            beat_load_o,
  // Sideband aligned with the lane registers
  output masku_pkg::beat_info_t                           beat_info_o,
  output logic                                            stage_valid_o
);

  // Bits covered by one beat over all lanes
  localparam masku_pkg::vlen_t BEAT_BITS =
    masku_pkg::vlen_t'(`MASKU_NR_LANES * `MASKU_ELEN);

  //////////////////////////////
  // Instruction register
  //////////////////////////////

  // Queue of depth one
  masku_pkg::masku_req_t insn_q;
  logic                  insn_valid_q;
  masku_pkg::vlen_t      remaining_q;
  masku_pkg::vlen_t      remaining_next;

  // Lane stage occupancy and its sideband
  logic                  stage_valid_q;
  masku_pkg::beat_info_t beat_info_q;

  logic req_fire;
  logic beat_last;

  // Free whenever nothing is held, also right after reset
  assign req_ready_o = !insn_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;

  // Stage is empty or drained in this same cycle
  assign opnd_ready_o = insn_valid_q && (!stage_valid_q || stage_ready_i);
  assign beat_load_o  = opnd_valid_i && opnd_ready_o;

  // Last beat once the rest fits into one beat
  assign beat_last = (remaining_q <= BEAT_BITS);

  // Saturating decrement
  assign remaining_next = beat_last ? '0 : remaining_q - BEAT_BITS;

  //////////////////////////////
  // Beat control
  //////////////////////////////

  // Count at the start of the beat goes to the lanes
  assign lane_ctrl_o = '{op: insn_q.op, vm: insn_q.vm, remaining: remaining_q};
  // Lane words go straight to the lane registers
  assign lane_opnd_o = opnd_i;

  assign beat_info_o   = beat_info_q;
  assign stage_valid_o = stage_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid_q  <= 1'b0;
      remaining_q   <= '0;
      stage_valid_q <= 1'b0;
    end else begin
      if (req_fire) begin
        insn_valid_q <= 1'b1;
        remaining_q  <= req_i.vl;
      end else if (beat_load_o) begin
        remaining_q <= remaining_next;
        // Release on the edge taking the last beat
        if (beat_last) begin
          insn_valid_q <= 1'b0;
        end
      end
      // Stage fills on a load, empties when the collector takes it
      if (beat_load_o) begin
        stage_valid_q <= 1'b1;
      end else if (stage_ready_i) begin
        stage_valid_q <= 1'b0;
      end
    end
  end

  // Instruction payload and beat sideband
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      insn_q <= req_i;
    end
    if (beat_load_o) begin
      beat_info_q <= '{op: insn_q.op, id: insn_q.id, last: beat_last};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/masku_top.sv ====
// Mask unit top level: sequencer, one slice per lane and the collector
`default_nettype none
`timescale 1ns/1ps

`include "masku_config.svh"

module masku_top (
  input  wire logic                                           clk_i,
  input  wire logic                                           rst_ni,
  // Request channel
  input  wire masku_pkg::masku_req_t                          req_i,
  input  wire logic                                           req_valid_i,
  output logic                                                req_ready_o,
  // Operand channel, one valid for all lanes
  input  wire masku_pkg::lane_operand_t [`MASKU_NR_LANES-1:0] opnd_i,
  input  wire logic                                           opnd_valid_i,
  output logic                                                opnd_ready_o,
  // Result channel
  output masku_pkg::lane_word_t [`MASKU_NR_LANES-1:0]         res_wdata_o,
  output masku_pkg::lane_strb_t [`MASKU_NR_LANES-1:0]         res_be_o,
  output logic                                                res_valid_o,
  input  wire logic                                           res_ready_i,
  // Scalar channel
  output masku_pkg::scalar_t                                  scalar_o,
  output logic                                                scalar_valid_o,
  input  wire logic                                           scalar_ready_i,
  // Completion
  output logic                                                done_o,
  output masku_pkg::insn_id_t                                 done_id_o
);

  localparam int unsigned NR_LANES = `MASKU_NR_LANES;

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  masku_pkg::lane_ctrl_t                   lane_ctrl;
  masku_pkg::lane_operand_t [NR_LANES-1:0] lane_opnd;
  masku_pkg::lane_result_t  [NR_LANES-1:0] lane_res;
  masku_pkg::beat_info_t                   beat_info;
  logic                                    beat_load;
  logic                                    stage_valid;
  logic                                    stage_ready;

  // Instruction and beat control
  masku_sequencer i_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .opnd_i        (opnd_i),
    .opnd_valid_i  (opnd_valid_i),
    .opnd_ready_o  (opnd_ready_o),
    .stage_ready_i (stage_ready),
    .lane_ctrl_o   (lane_ctrl),
    .lane_opnd_o   (lane_opnd),
    .beat_load_o   (beat_load),
    .beat_info_o   (beat_info),
    .stage_valid_o (stage_valid)
  );

  // Lane stage, all slices load together
  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    masku_lane_slice #(
      .LANE_IDX (l)
    ) i_lane_slice (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .lane_ctrl_i (lane_ctrl),
      .lane_opnd_i (lane_opnd[l]),
      .beat_load_i (beat_load),
      .lane_res_o  (lane_res[l])
    );
  end

  // Result beats, scalar and done
  masku_collector i_collector (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_res_i     (lane_res),
    .beat_info_i    (beat_info),
    .stage_valid_i  (stage_valid),
    .stage_ready_o  (stage_ready),
    .res_wdata_o    (res_wdata_o),
    .res_be_o       (res_be_o),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .scalar_o       (scalar_o),
    .scalar_valid_o (scalar_valid_o),
    .scalar_ready_i (scalar_ready_i),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

endmodule

`default_nettype wire
